// ==== project.f ====
rtl/hazardPkg.sv
rtl/instrDecode.sv
rtl/stageTracker.sv
rtl/hazardCompare.sv
rtl/hazardResolve.sv
rtl/hazardUnit.sv
sim/hazardTbPkg.sv
sim/hazardTb.sv

// ==== rtl/hazardCompare.sv ====
// RAW check of the fetched instruction against one downstream slot
`timescale 1ns/1ps
`default_nettype none

module hazardCompare import hazardPkg::*; #(
	// number of stages between the fetched instruction and the slot where 1 means ID/EX
	parameter int STAGE_DIST = 1
) (
	input  wire instrInfoT fetchInfo,
	input  wire instrInfoT slotInfo,
	output logic           stall
);

	// the slot produces a register that the fetched instruction reads
	logic rs1Match;
	logic rs2Match;
	logic raw;

	// regWrite is already cleared for x0, so x0 never matches
	// the uses flags carry the fetch valid while the slot valid is checked here
	assign rs1Match = fetchInfo.usesRs1 & (fetchInfo.rs1 == slotInfo.rd);
	assign rs2Match = fetchInfo.usesRs2 & (fetchInfo.rs2 == slotInfo.rd);
	assign raw      = slotInfo.valid & slotInfo.regWrite & (rs1Match | rs2Match);

	// which producers are too late depends on how far down the slot is
	always_comb begin
		stall = 1'b0;
		if (STAGE_DIST == 1) begin
			// load data only exists after MEM, so anyone reading it right behind waits
			// a branch resolves in ID, before even an ALU result can be forwarded
			stall = raw & (slotInfo.memRead | fetchInfo.isBranch);
		end else if (STAGE_DIST == 2) begin
			// ALU results are forwardable to ID by now but load data still is not
			stall = raw & slotInfo.memRead & fetchInfo.isBranch;
		end
		// further slots have written back or forward in time so they need no stall
	end

endmodule

`default_nettype wire

// ==== rtl/hazardPkg.sv ====
// shared types and constants for the RV32I pipeline hazard control block
`default_nettype none

package hazardPkg;

	// index into the 32-entry integer register file
	typedef logic [4:0] regAddrT;

	// register-use summary of one decoded instruction
	// this is what the hazard checks need, nothing of the datapath payload travels here
	typedef struct packed {
		// the slot holds a real instruction, not a bubble
		logic    valid;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		// which source fields are actually read by the opcode
		logic    usesRs1;
		logic    usesRs2;
		// cleared for rd == x0 since such a write can never feed anyone
		logic    regWrite;
		// loads deliver their result late, after MEM
		logic    memRead;
		// conditional branches and JALR, both resolved early in ID
		logic    isBranch;
		logic    isEcall;
		// direction predicted in fetch, compared against the resolved outcome later
		logic    predTaken;
	} instrInfoT;

	// major opcodes of the base integer set, bits [6:0] of the instruction word
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// ID/EX and EX/MEM are the two slots that can still hold an unwritten result
	localparam int DEFAULT_STAGES = 2;

endpackage

`default_nettype wire

// ==== rtl/hazardResolve.sv ====
// merges slot stalls, ECALL and branch misprediction into PC and pipeline control
`timescale 1ns/1ps
`default_nettype none

module hazardResolve import hazardPkg::*; #(
	parameter int NUM_STAGES = DEFAULT_STAGES
) (
	input  wire logic [NUM_STAGES-1:0] slotStall,
	input  wire instrInfoT             fetchInfo,
	// the branch now in ID/EX whose outcome is being reported
	input  wire instrInfoT             resolveInfo,
	input  wire logic                  takeBranch,
	output logic                       pcEnable,
	output logic                       flushIfId,
	output logic                       holdIfId,
	output logic                       bubbleIdEx,
	output logic                       mispredict
);

	logic stall;
	logic ecallHold;

	// any slot can hold the fetched instruction back, but only a real one
	assign stall = (|slotStall) & fetchInfo.valid;

	// an ECALL freezes the PC until the trap path takes over
	// it does not need a bubble because it reads no register
	assign ecallHold = fetchInfo.valid & fetchInfo.isEcall;

	// the prediction travelled with the branch, so it is compared in place
	assign mispredict = resolveInfo.valid & resolveInfo.isBranch &
		(takeBranch != resolveInfo.predTaken);

	// a misprediction redirects the PC even if the wrong-path fetch would stall,
	// because that fetch is about to be flushed anyway
	assign pcEnable = mispredict | ~(stall | ecallHold);

	// the wrong-path word in IF/ID is thrown away
	assign flushIfId = mispredict;

	// the held word is kept in IF/ID only when it is still on the right path
	assign holdIfId = stall & ~mispredict;

	// ID/EX gets a NOP both while waiting and behind a flushed fetch
	assign bubbleIdEx = stall | mispredict;

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
// hazard control top for the five-stage RV32I pipeline with early branch resolution
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import hazardPkg::*; #(
	// downstream slots tracked, ID/EX and EX/MEM by default
	parameter int NUM_STAGES = DEFAULT_STAGES
) (
	input  wire logic        clk,
	input  wire logic        rstN,
	// the word leaving fetch and entering IF/ID
	input  wire logic [31:0] fetchInstr,
	input  wire logic        fetchValid,
	input  wire logic        fetchPredTaken,
	// resolved direction of the branch sitting in ID/EX
	input  wire logic        takeBranch,
	// goes straight to the PC register enable
	output logic             pcEnable,
	output logic             flushIfId,
	output logic             holdIfId,
	output logic             bubbleIdEx,
	output logic             mispredict
);

	// decoded view of the fetched word
	instrInfoT fetchInfo;

	// instructions in flight, index 0 is ID/EX
	instrInfoT [NUM_STAGES-1:0] slotInfo;

	// one RAW stall request per tracked slot
	logic [NUM_STAGES-1:0] slotStall;

	instrDecode uDecode (
		.instr      (fetchInstr),
		.instrValid (fetchValid),
		.predTaken  (fetchPredTaken),
		.info       (fetchInfo)
	);

	// the bubble decision feeds back so a stalled word does not enter ID/EX
	stageTracker #(
		.NUM_STAGES (NUM_STAGES)
	) uTracker (
		.clk      (clk),
		.rstN     (rstN),
		.inInfo   (fetchInfo),
		.bubble   (bubbleIdEx),
		.slotInfo (slotInfo)
	);

	// slot k sits k+1 stages ahead of the fetched instruction
	// slot 0 covers load-to-use and ALU-to-branch, slot 1 covers load-to-branch
	for (genvar k = 0; k < NUM_STAGES; k++) begin : gCompare
		hazardCompare #(
			.STAGE_DIST (k + 1)
		) uCompare (
			.fetchInfo (fetchInfo),
			.slotInfo  (slotInfo[k]),
			.stall     (slotStall[k])
		);
	end

	// all outputs are combinational from the fetch word and the tracker state
	hazardResolve #(
		.NUM_STAGES (NUM_STAGES)
	) uResolve (
		.slotStall   (slotStall),
		.fetchInfo   (fetchInfo),
		.resolveInfo (slotInfo[0]),
		.takeBranch  (takeBranch),
		.pcEnable    (pcEnable),
		.flushIfId   (flushIfId),
		.holdIfId    (holdIfId),
		.bubbleIdEx  (bubbleIdEx),
		.mispredict  (mispredict)
	);

endmodule

`default_nettype wire

// ==== rtl/instrDecode.sv ====
// decodes a fetched RV32I word into the register fields it reads and writes
`timescale 1ns/1ps
`default_nettype none

module instrDecode import hazardPkg::*; (
	input  wire logic [31:0] instr,
	input  wire logic        instrValid,
	input  wire logic        predTaken,
	output instrInfoT        info
);

	logic [6:0]  opcode;
	logic [11:0] funct12;
	regAddrT     rdField;

	// per-opcode usage before the valid qualifier is applied
	logic readsRs1;
	logic readsRs2;
	logic writesRd;

	assign opcode  = instr[6:0];
	assign funct12 = instr[31:20];
	assign rdField = instr[11:7];

	// the opcode alone decides which source fields carry real registers
	// unknown opcodes fall through with nothing used, so they can never stall
	always_comb begin
		readsRs1 = 1'b0;
		readsRs2 = 1'b0;
		writesRd = 1'b0;
		case (opcode)
			OPC_OP: begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
				writesRd = 1'b1;
			end
			// branches compare two registers and write nothing
			OPC_BRANCH: begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
			end
			// stores read base and data, the rd field is part of the offset
			OPC_STORE: begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
			end
			OPC_LOAD, OPC_OPIMM, OPC_JALR: begin
				readsRs1 = 1'b1;
				writesRd = 1'b1;
			end
			// upper-immediate forms and JAL only produce a result
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				writesRd = 1'b1;
			end
			// SYSTEM writes nothing here since CSR access lives outside this block
			default: begin
			end
		endcase
	end

	// every flag is qualified by instrValid so an empty fetch slot matches nothing
	always_comb begin
		info           = '0;
		info.valid     = instrValid;
		info.rs1       = instr[19:15];
		info.rs2       = instr[24:20];
		info.rd        = rdField;
		info.usesRs1   = instrValid & readsRs1;
		info.usesRs2   = instrValid & readsRs2;
		// a write to x0 is discarded, so it is not a producer for hazard purposes
		info.regWrite  = instrValid & writesRd & (rdField != '0);
		info.memRead   = instrValid & (opcode == OPC_LOAD);
		info.isBranch  = instrValid & ((opcode == OPC_BRANCH) | (opcode == OPC_JALR));
		// EBREAK has funct12 of one, so only a zero funct12 counts as ECALL
		info.isEcall   = instrValid & (opcode == OPC_SYSTEM) & (funct12 == '0);
		info.predTaken = predTaken;
	end

endmodule

`default_nettype wire

// ==== rtl/stageTracker.sv ====
// shadow shift register of decoded instructions in the ID/EX and EX/MEM slots
`timescale 1ns/1ps
`default_nettype none

module stageTracker import hazardPkg::*; #(
	parameter int NUM_STAGES = DEFAULT_STAGES
) (
	input  wire logic                   clk,
	input  wire logic                   rstN,
	input  wire instrInfoT              inInfo,
	input  wire logic                   bubble,
	output instrInfoT [NUM_STAGES-1:0] slotInfo
);

	// slot 0 mirrors ID/EX and each higher index is one stage further down
	instrInfoT [NUM_STAGES-1:0] slotQ;

	// what enters ID/EX on the next edge
	instrInfoT entryInfo;

	// a bubble replaces the decoded word with an all-zero entry
	// an invalid fetch already arrives with valid low and every flag cleared
	always_comb begin
		if (bubble) begin
			entryInfo = '0;
		end else begin
			entryInfo = inInfo;
		end
	end

	// the slots only ever shift because nothing below ID/EX stalls in this pipeline
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// both slots empty out of reset, so no hazard can be seen yet
			slotQ <= '0;
		end else begin
			slotQ[0] <= entryInfo;
			for (int k = 1; k < NUM_STAGES; k++) begin
				slotQ[k] <= slotQ[k-1];
			end
		end
	end

	// this history replaces the instruction words the core would otherwise pass in
	// from its own pipeline registers
	assign slotInfo = slotQ;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds the hazard unit testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module hazardTb -f project.f -o simv \
	&& { simOut="$(./obj_dir/simv)"; echo "$simOut"; grep -qx "TESTS PASSED" <<< "$simOut"; } \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// ==== sim/hazardTb.sv ====
// testbench for the hazard unit running directed hazard sequences and then a random stream
`timescale 1ns/1ps
`default_nettype none

module hazardTb
	import hazardPkg::*, hazardTbPkg::*;
();

	localparam int RESET_CYCLES   = 16;
	localparam int RANDOM_CYCLES  = 2000;
	// the directed part needs about 100 cycles, the random part is counted in cycles
	localparam int TIMEOUT_CYCLES = 2200;

	logic        clk;
	logic        rstN;
	logic [31:0] fetchInstr;
	logic        fetchValid;
	logic        fetchPredTaken;
	logic        takeBranch;
	logic        pcEnable;
	logic        flushIfId;
	logic        holdIfId;
	logic        bubbleIdEx;
	logic        mispredict;

	string       testName;
	int          cycleCount = 0;
	// number of cycles the last presented word was held in IF/ID
	int          lastHold;
	logic [31:0] lfsrState;

	// model copies of the ID/EX and EX/MEM slots
	instrInfoT   modelSlot0;
	instrInfoT   modelSlot1;
	ctrlT        expCtrl;

	hazardUnit #(
		.NUM_STAGES (DEFAULT_STAGES)
	) dut_i (
		.clk            (clk),
		.rstN           (rstN),
		.fetchInstr     (fetchInstr),
		.fetchValid     (fetchValid),
		.fetchPredTaken (fetchPredTaken),
		.takeBranch     (takeBranch),
		.pcEnable       (pcEnable),
		.flushIfId      (flushIfId),
		.holdIfId       (holdIfId),
		.bubbleIdEx     (bubbleIdEx),
		.mispredict     (mispredict)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic stopRun();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkBit(input string what, input logic expVal, input logic actVal);
		assert (actVal === expVal) else begin
			$display("** Error %s %s: expected %b, actual %b", testName, what, expVal, actVal);
			stopRun();
		end
	endtask

	task automatic checkCount(input string what, input int expVal, input int actVal);
		assert (actVal == expVal) else begin
			$display("** Error %s %s: expected %0d, actual %0d", testName, what, expVal, actVal);
			stopRun();
		end
	endtask

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	// drives one word on the rising edge and keeps it there while the DUT holds IF/ID
	task automatic present(input logic [31:0] word, input logic valid, input logic pred,
		input logic take);
		int held;
		held = 0;
		@(posedge clk);
		fetchInstr     <= word;
		fetchValid     <= valid;
		fetchPredTaken <= pred;
		takeBranch     <= take;
		@(negedge clk);
		while (holdIfId) begin
			held++;
			@(negedge clk);
		end
		lastHold = held;
	endtask

	task automatic idle(input int count);
		repeat (count) present(genNop(), 1'b1, 1'b0, 1'b0);
	endtask

	always_comb begin
		expCtrl = refOutputs(modelSlot0, modelSlot1, fetchInstr, fetchValid, fetchPredTaken,
			takeBranch);
	end

	// the model slots advance on the same edge as the DUT tracker
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			modelSlot0 <= '0;
			modelSlot1 <= '0;
		end else begin
			modelSlot1 <= modelSlot0;
			if (expCtrl.bubbleIdEx || !fetchValid) begin
				modelSlot0 <= '0;
			end else begin
				modelSlot0 <= decodeWord(fetchInstr, fetchValid, fetchPredTaken);
			end
		end
	end

	// outputs are settled at the falling edge, half a cycle after the inputs changed
	always @(negedge clk) begin
		if (rstN) begin
			checkBit("pcEnable", expCtrl.pcEnable, pcEnable);
			checkBit("flushIfId", expCtrl.flushIfId, flushIfId);
			checkBit("holdIfId", expCtrl.holdIfId, holdIfId);
			checkBit("bubbleIdEx", expCtrl.bubbleIdEx, bubbleIdEx);
			checkBit("mispredict", expCtrl.mispredict, mispredict);
		end
	end

	always @(posedge clk) begin
		if (rstN) begin
			cycleCount <= cycleCount + 1;
			if (cycleCount >= TIMEOUT_CYCLES) begin
				$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
				stopRun();
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] word;
		regAddrT     rdR;
		regAddrT     rs1R;
		regAddrT     rs2R;
		int          startCycle;
		fetchInstr     = genNop();
		fetchValid     = 1'b0;
		fetchPredTaken = 1'b0;
		takeBranch     = 1'b0;
		rstN           = 1'b0;
		lfsrState      = LFSR_SEED;
		testName       = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkBit("pcEnable after reset", 1'b1, pcEnable);

		// load x1, then a reader of x1 waits one cycle, an x0 pair waits none
		testName = "loadUse";
		present(genLoad(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genAlu(5'd3, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		checkCount("hold cycles", 1, lastHold);
		idle(3);
		present(genLoad(5'd0, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genAlu(5'd3, 5'd0, 5'd0), 1'b1, 1'b0, 1'b0);
		checkCount("x0 hold cycles", 0, lastHold);
		idle(4);

		testName = "branchDeps";
		present(genAlu(5'd1, 5'd2, 5'd3), 1'b1, 1'b0, 1'b0);
		present(genBranch(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		checkCount("alu hold cycles", 1, lastHold);
		idle(3);
		present(genLoad(5'd2, 5'd3), 1'b1, 1'b0, 1'b0);
		present(genBranch(5'd2, 5'd0), 1'b1, 1'b0, 1'b0);
		checkCount("load hold cycles", 2, lastHold);
		idle(4);

		// x1 only appears in fields that these formats do not read
		testName = "unusedFields";
		present(genLoad(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genStore(5'd2, 5'd3, 5'd1), 1'b1, 1'b0, 1'b0);
		checkCount("store hold cycles", 0, lastHold);
		present(genLoad(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genLui(5'd2, 5'd1), 1'b1, 1'b0, 1'b0);
		checkCount("lui hold cycles", 0, lastHold);
		present(genLoad(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genJal(5'd3, 5'd1), 1'b1, 1'b0, 1'b0);
		checkCount("jal hold cycles", 0, lastHold);
		idle(4);

		testName = "ecall";
		repeat (3) begin
			present(genEcall(), 1'b1, 1'b0, 1'b0);
			checkBit("ecall pcEnable", 1'b0, pcEnable);
			checkBit("ecall bubbleIdEx", 1'b0, bubbleIdEx);
		end
		idle(4);

		// the JALR writes x1 and is mispredicted while a branch on x1 waits behind it
		testName = "mispredict";
		present(genJalr(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genBranch(5'd1, 5'd0), 1'b1, 1'b0, 1'b1);
		checkBit("override mispredict", 1'b1, mispredict);
		checkBit("override holdIfId", 1'b0, holdIfId);
		checkBit("override pcEnable", 1'b1, pcEnable);
		present(genBranch(5'd2, 5'd3), 1'b1, 1'b1, 1'b0);
		present(genNop(), 1'b1, 1'b0, 1'b1);
		checkBit("match mispredict", 1'b0, mispredict);
		idle(4);

		testName = "invalidFetch";
		present(genLoad(5'd1, 5'd2), 1'b1, 1'b0, 1'b0);
		present(genAlu(5'd3, 5'd1, 5'd1), 1'b0, 1'b0, 1'b0);
		checkCount("invalid hold cycles", 0, lastHold);
		present(genEcall(), 1'b0, 1'b0, 1'b0);
		checkBit("invalid ecall pcEnable", 1'b1, pcEnable);
		idle(4);

		// registers x0 to x3 only, so dependences are common
		testName = "random";
		startCycle = cycleCount;
		while (cycleCount - startCycle < RANDOM_CYCLES) begin
			rnd  = takeBits(15);
			rdR  = {3'b000, rnd[1:0]};
			rs1R = {3'b000, rnd[3:2]};
			rs2R = {3'b000, rnd[5:4]};
			case (rnd[8:6])
				3'd0: word = genLoad(rdR, rs1R);
				3'd1: word = genAlu(rdR, rs1R, rs2R);
				3'd2: word = genBranch(rs1R, rs2R);
				3'd3: word = genStore(rs1R, rs2R, rdR);
				3'd4: word = genJal(rdR, rs1R);
				3'd5: word = genEcall();
				3'd6: word = genJalr(rdR, rs1R);
				default: word = genLui(rdR, rs2R);
			endcase
			present(word, rnd[11:9] != 3'd0, rnd[12], rnd[13]);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/hazardTbPkg.sv ====
// testbench helpers for the hazard unit with a random source, instruction builders and a reference model
`default_nettype none

package hazardTbPkg;
	import hazardPkg::*;

	localparam logic [31:0] LFSR_SEED = 32'hff85451d;

	// expected control outputs, one field per DUT output
	typedef struct packed {
		logic pcEnable;
		logic flushIfId;
		logic holdIfId;
		logic bubbleIdEx;
		logic mispredict;
	} ctrlT;

	// x^32 + x^22 + x^2 + x + 1, the feedback bit enters at bit 0
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	// instruction builders, the unused fields are left open so tests can fill them with registers
	function automatic logic [31:0] genLoad(input regAddrT rd, input regAddrT rs1);
		return {12'h004, rs1, 3'b010, rd, OPC_LOAD};
	endfunction

	function automatic logic [31:0] genAlu(input regAddrT rd, input regAddrT rs1, input regAddrT rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] genBranch(input regAddrT rs1, input regAddrT rs2);
		return {7'b0000000, rs2, rs1, 3'b001, 5'b01000, OPC_BRANCH};
	endfunction

	function automatic logic [31:0] genJalr(input regAddrT rd, input regAddrT rs1);
		return {12'h000, rs1, 3'b000, rd, OPC_JALR};
	endfunction

	// off lands in the rd position, which a store uses as offset bits
	function automatic logic [31:0] genStore(input regAddrT rs1, input regAddrT rs2, input regAddrT off);
		return {7'b0000000, rs2, rs1, 3'b010, off, OPC_STORE};
	endfunction

	// fill lands where rs1 and rs2 would sit, yet both are immediate bits here
	function automatic logic [31:0] genLui(input regAddrT rd, input regAddrT fill);
		return {7'b0000000, fill, fill, 3'b000, rd, OPC_LUI};
	endfunction

	function automatic logic [31:0] genJal(input regAddrT rd, input regAddrT fill);
		return {7'b0000000, fill, fill, 3'b000, rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] genEcall();
		return {25'd0, OPC_SYSTEM};
	endfunction

	// ADDI x0, x0, 0 has an x0 destination, so it never produces anything
	function automatic logic [31:0] genNop();
		return {25'd0, OPC_OPIMM};
	endfunction

	// register use of a word as the RV32I formats define it
	function automatic instrInfoT decodeWord(input logic [31:0] word, input logic valid,
		input logic pred);
		instrInfoT info;
		logic [6:0] opc;
		opc = word[6:0];
		info = '0;
		info.predTaken = pred;
		if (valid) begin
			info.valid    = 1'b1;
			info.rs1      = word[19:15];
			info.rs2      = word[24:20];
			info.rd       = word[11:7];
			info.usesRs1  = opc inside {OPC_OP, OPC_BRANCH, OPC_STORE, OPC_LOAD, OPC_OPIMM, OPC_JALR};
			info.usesRs2  = opc inside {OPC_OP, OPC_BRANCH, OPC_STORE};
			info.regWrite = (opc inside {OPC_OP, OPC_LOAD, OPC_OPIMM, OPC_JALR, OPC_LUI, OPC_AUIPC,
				OPC_JAL}) && (word[11:7] != 5'd0);
			info.memRead  = (opc == OPC_LOAD);
			info.isBranch = (opc == OPC_BRANCH) || (opc == OPC_JALR);
			info.isEcall  = (opc == OPC_SYSTEM) && (word[31:20] == 12'd0);
		end
		return info;
	endfunction

	// the older instruction writes a register that the fetched one reads
	function automatic logic dependsOn(input instrInfoT fetch, input instrInfoT older);
		logic hit1;
		logic hit2;
		hit1 = fetch.usesRs1 && (fetch.rs1 == older.rd);
		hit2 = fetch.usesRs2 && (fetch.rs2 == older.rd);
		return older.valid && older.regWrite && (hit1 || hit2);
	endfunction

	// expected outputs from the two model slots and the word now presented
	function automatic ctrlT refOutputs(input instrInfoT slot0, input instrInfoT slot1,
		input logic [31:0] word, input logic valid, input logic pred, input logic take);
		instrInfoT fetch;
		logic loadUse;
		logic aluBranch;
		logic loadBranch;
		logic stall;
		ctrlT res;
		fetch      = decodeWord(word, valid, pred);
		loadUse    = dependsOn(fetch, slot0) && slot0.memRead;
		aluBranch  = dependsOn(fetch, slot0) && fetch.isBranch;
		loadBranch = dependsOn(fetch, slot1) && slot1.memRead && fetch.isBranch;
		stall      = valid && (loadUse || aluBranch || loadBranch);
		res.mispredict = slot0.valid && slot0.isBranch && (take != slot0.predTaken);
		res.pcEnable   = res.mispredict || !(stall || (valid && fetch.isEcall));
		res.flushIfId  = res.mispredict;
		res.holdIfId   = stall && !res.mispredict;
		res.bubbleIdEx = stall || res.mispredict;
		return res;
	endfunction

endpackage

`default_nettype wire
